// ==== rtl/block_game_settings.svh ====
`ifndef BLOCK_GAME_SETTINGS_SVH
`define BLOCK_GAME_SETTINGS_SVH

// Pixel plotter geometry
`define COORD_X_WIDTH 8
`define COORD_Y_WIDTH 7
`define COLOUR_WIDTH 3

`define BLOCK_SIZE 20 // Side of a drawn square in pixels
`define BLOCK_STEP 21 // Lane pitch and the distance a block moves per frame

// Lane layout, first lane corner on each axis
`define LANE_COUNT 5
`define LANE_ORIGIN_X 27
`define LANE_ORIGIN_Y 7
`define LANE_LAST_X (`LANE_ORIGIN_X + (`LANE_COUNT - 1) * `BLOCK_STEP)
`define LANE_LAST_Y (`LANE_ORIGIN_Y + (`LANE_COUNT - 1) * `BLOCK_STEP)

`define SLOT_COUNT 10

`define BLOCK_COLOUR 3'd4 // Red
`define ERASE_COLOUR 3'd0

`define FRAME_DELAY 64 // Hold cycles between draw and erase, short for simulation

`endif

// ==== rtl/screen_pkg.sv ====
`include "block_game_settings.svh"

package screen_pkg;

	// Pixel coordinates on the plotter
	typedef logic [`COORD_X_WIDTH-1:0] coord_x_t;
	typedef logic [`COORD_Y_WIDTH-1:0] coord_y_t;

	typedef logic [`COLOUR_WIDTH-1:0] colour_t;

	// One pixel handed to the plotter
	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		colour_t colour;
	} pixel_t;

endpackage

// ==== rtl/game_pkg.sv ====
`include "block_game_settings.svh"

package game_pkg;

	import screen_pkg::*;

	typedef logic [$clog2(`LANE_COUNT)-1:0] lane_t;
	typedef logic [$clog2(`SLOT_COUNT)-1:0] slot_index_t;

	// Direction of travel, sampled at spawn and stored with each block
	typedef enum logic [1:0] {
		heading_down,
		heading_left,
		heading_up,
		heading_right
	} heading_t;

	// The x and y fields give the upper left corner and a clear occupied bit marks an empty slot
	typedef struct packed {
		logic occupied;
		heading_t heading;
		coord_x_t x;
		coord_y_t y;
	} block_t;

	typedef enum logic [2:0] {
		state_idle, // Waiting for go
		state_armed, // Waiting for go to be released
		state_capture,
		state_load,
		state_draw,
		state_hold,
		state_erase,
		state_step
	} game_state_t;

endpackage

// ==== rtl/game_control.sv ====
`include "block_game_settings.svh"

module game_control
	import game_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic go,
	input logic paint_done,
	output logic capture,
	output logic load,
	output logic step,
	output logic paint_start,
	output logic erase
);

	game_state_t state;
	game_state_t next_state;
	logic pass_busy; // Painter has been started in this state
	logic [$clog2(`FRAME_DELAY)-1:0] hold_count;
	logic hold_done;

	assign hold_done = (hold_count == `FRAME_DELAY - 1);

	always_comb
	begin
		next_state = state;
		case (state)
			state_idle: if (go) next_state = state_armed;
			state_armed: if (!go) next_state = state_capture;
			state_capture: next_state = state_load;
			state_load: next_state = state_draw;
			state_draw: if (paint_done) next_state = state_hold;
			state_hold: if (hold_done) next_state = state_erase;
			state_erase: if (paint_done) next_state = state_step;
			state_step: next_state = state_capture;
			default: next_state = state_idle;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!reset)
			state <= state_idle;
		else
			state <= next_state;
	end

	// Counts the hold, restarts whenever the state is left
	always_ff @(posedge clock)
	begin
		if (!reset || state != state_hold)
			hold_count <= '0;
		else
			hold_count <= hold_count + 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (!reset)
			pass_busy <= 1'b0;
		else if (paint_done)
			pass_busy <= 1'b0;
		else if (paint_start)
			pass_busy <= 1'b1;
	end

	assign capture = (state == state_capture);
	assign load = (state == state_load);
	assign step = (state == state_step);
	assign erase = (state == state_erase);
	assign paint_start = (state == state_draw || state == state_erase) && !pass_busy;

	// The painter must only finish a pass that this controller started
	paint_done_in_pass: assert property (@(posedge clock) disable iff (!reset)
		paint_done |-> (state == state_draw || state == state_erase) && pass_busy);

endmodule

// ==== rtl/lane_generator.sv ====
`include "block_game_settings.svh"

module lane_generator
	import screen_pkg::*;
	import game_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic capture,
	input heading_t heading,
	output block_t spawn_block
);

	lane_t count; // Free running, sampled at capture
	lane_t current;
	lane_t lane;

	// A sample next to the previous one is pushed one lane further away
	always_comb
	begin
		if (count == current + 1)
			lane = (count == `LANE_COUNT - 1) ? lane_t'(0) : lane_t'(count + 1'b1);
		else if (count == current - 1)
			lane = (count == 0) ? lane_t'(`LANE_COUNT - 1) : lane_t'(count - 1'b1);
		else
			lane = count;
	end

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			count <= '0;
			current <= '1; // No lane holds all ones, so the first sample is never bent
		end
		else
		begin
			count <= (count == `LANE_COUNT - 1) ? '0 : count + 1'b1;
			if (capture)
				current <= count;
		end
	end

	// Entry edge follows the heading, the lane picks the position along it
	always_ff @(posedge clock)
	begin
		if (capture)
		begin
			spawn_block.occupied <= 1'b1;
			spawn_block.heading <= heading;
			case (heading)
				heading_down: spawn_block.y <= coord_y_t'(`LANE_ORIGIN_Y);
				heading_up: spawn_block.y <= coord_y_t'(`LANE_LAST_Y);
				default: spawn_block.y <= coord_y_t'(`LANE_ORIGIN_Y + lane * `BLOCK_STEP);
			endcase
			case (heading)
				heading_left: spawn_block.x <= coord_x_t'(`LANE_LAST_X);
				heading_right: spawn_block.x <= coord_x_t'(`LANE_ORIGIN_X);
				default: spawn_block.x <= coord_x_t'(`LANE_ORIGIN_X + lane * `BLOCK_STEP);
			endcase
		end
	end

endmodule

// ==== rtl/block_slots.sv ====
`include "block_game_settings.svh"

module block_slots
	import screen_pkg::*;
	import game_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic load,
	input logic step,
	input block_t spawn_block,
	input slot_index_t slot_index,
	output block_t slot_block
);

	block_t slots [`SLOT_COUNT];
	slot_index_t wr_ptr;

	// Moves one block a lane pitch, or drops it once it sits on its exit edge
	function automatic block_t step_block(block_t blk);
		block_t moved;
		moved = blk;
		if (blk.occupied)
		begin
			case (blk.heading)
				heading_down:
					if (blk.y == `LANE_LAST_Y)
						moved.occupied = 1'b0;
					else
						moved.y = blk.y + coord_y_t'(`BLOCK_STEP);
				heading_left:
					if (blk.x == `LANE_ORIGIN_X)
						moved.occupied = 1'b0;
					else
						moved.x = blk.x - coord_x_t'(`BLOCK_STEP);
				heading_up:
					if (blk.y == `LANE_ORIGIN_Y)
						moved.occupied = 1'b0;
					else
						moved.y = blk.y - coord_y_t'(`BLOCK_STEP);
				default:
					if (blk.x == `LANE_LAST_X)
						moved.occupied = 1'b0;
					else
						moved.x = blk.x + coord_x_t'(`BLOCK_STEP);
			endcase
		end
		return moved;
	endfunction

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			wr_ptr <= '0;
			for (int i = 0; i < `SLOT_COUNT; i++)
				slots[i].occupied <= 1'b0;
		end
		else if (load)
		begin
			slots[wr_ptr] <= spawn_block;
			wr_ptr <= (wr_ptr == `SLOT_COUNT - 1) ? '0 : wr_ptr + 1'b1;
		end
		else if (step)
		begin
			for (int i = 0; i < `SLOT_COUNT; i++)
				slots[i] <= step_block(slots[i]);
		end
	end

	always_comb
	begin
		if (slot_index < `SLOT_COUNT)
			slot_block = slots[slot_index];
		else
			slot_block = '0;
	end

	no_load_during_step: assert property (@(posedge clock) disable iff (!reset)
		!(load && step));

endmodule

// ==== rtl/square_painter.sv ====
`include "block_game_settings.svh"

module square_painter
	import screen_pkg::*;
	import game_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic paint_start,
	input logic erase,
	input block_t slot_block,
	output slot_index_t slot_index,
	output logic plot,
	output pixel_t pixel,
	output logic paint_done
);

	typedef enum logic {paint_idle, paint_busy} paint_state_t;

	paint_state_t state;
	logic [$clog2(`BLOCK_SIZE)-1:0] col;
	logic [$clog2(`BLOCK_SIZE)-1:0] row;
	logic slot_done;

	// An empty slot is done at once, an occupied one after its last pixel
	assign slot_done = !slot_block.occupied
		|| (col == `BLOCK_SIZE - 1 && row == `BLOCK_SIZE - 1);

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			state <= paint_idle;
			slot_index <= '0;
			col <= '0;
			row <= '0;
			paint_done <= 1'b0;
		end
		else
		begin
			paint_done <= 1'b0;
			if (state == paint_idle)
			begin
				if (paint_start)
				begin
					state <= paint_busy;
					slot_index <= '0;
					col <= '0;
					row <= '0;
				end
			end
			else if (slot_done)
			begin
				col <= '0;
				row <= '0;
				if (slot_index == `SLOT_COUNT - 1)
				begin
					state <= paint_idle;
					paint_done <= 1'b1;
				end
				else
					slot_index <= slot_index + 1'b1;
			end
			else if (col == `BLOCK_SIZE - 1)
			begin
				col <= '0;
				row <= row + 1'b1;
			end
			else
				col <= col + 1'b1;
		end
	end

	assign plot = (state == paint_busy) && slot_block.occupied;

	always_comb
	begin
		pixel.x = slot_block.x + coord_x_t'(col);
		pixel.y = slot_block.y + coord_y_t'(row);
		pixel.colour = erase ? `ERASE_COLOUR : `BLOCK_COLOUR;
	end

	// Spawned and stepped blocks must keep every square inside the lane field
	pixel_in_field: assert property (@(posedge clock) disable iff (!reset)
		plot |-> (pixel.x <= `LANE_LAST_X + `BLOCK_SIZE - 1)
			&& (pixel.y <= `LANE_LAST_Y + `BLOCK_SIZE - 1));

endmodule

// ==== rtl/block_game_top.sv ====
module block_game_top
	import screen_pkg::*;
	import game_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic go,
	input heading_t heading,
	output logic plot,
	output pixel_t pixel
);

	logic capture;
	logic load;
	logic step;
	logic paint_start;
	logic paint_done;
	logic erase;
	block_t spawn_block;
	block_t slot_block;
	slot_index_t slot_index;

	game_control i_game_control (
		.clock(clock),
		.reset(reset),
		.go(go),
		.paint_done(paint_done),
		.capture(capture),
		.load(load),
		.step(step),
		.paint_start(paint_start),
		.erase(erase)
	);

	lane_generator i_lane_generator (
		.clock(clock),
		.reset(reset),
		.capture(capture),
		.heading(heading),
		.spawn_block(spawn_block)
	);

	block_slots i_block_slots (
		.clock(clock),
		.reset(reset),
		.load(load),
		.step(step),
		.spawn_block(spawn_block),
		.slot_index(slot_index),
		.slot_block(slot_block)
	);

	square_painter i_square_painter (
		.clock(clock),
		.reset(reset),
		.paint_start(paint_start),
		.erase(erase),
		.slot_block(slot_block),
		.slot_index(slot_index),
		.plot(plot),
		.pixel(pixel),
		.paint_done(paint_done)
	);

endmodule

// ==== verif/tb_block_game.sv ====
`include "block_game_settings.svh"

module tb_block_game
	import screen_pkg::*;
	import game_pkg::*;
();

	localparam int square_pixels = `BLOCK_SIZE * `BLOCK_SIZE;
	localparam int wait_limit = 500;
	localparam int pass_limit = `SLOT_COUNT * square_pixels + 100;
	localparam int quiet_end = 20; // Longer than any gap inside a pass, shorter than the hold

	logic clock = 1'b0;
	logic reset;
	logic go;
	heading_t heading;
	logic plot;
	pixel_t pixel;

	int value_errors = 0;
	int other_errors = 0;
	bit aborted = 1'b0;
	int frame; // Frames since the last go release

	int pat_heading [$];
	int pat_frames [$];
	int pat_count [$];

	coord_x_t draw_x [$];
	coord_y_t draw_y [$];
	block_t squares [$]; // Squares of the last frame with their headings

	block_game_top i_dut (
		.clock(clock),
		.reset(reset),
		.go(go),
		.heading(heading),
		.plot(plot),
		.pixel(pixel)
	);

	always #4 clock = ~clock;

	task automatic check_value(string name, int got, int expected);
		assert (got == expected)
		else
		begin
			value_errors++;
			$display("Error: %s got %h expected %h", name, got, expected);
		end
	endtask

	task automatic note_failure(string what);
		other_errors++;
		$display("%s", what);
	endtask

	task automatic drive_go(logic value);
		@(posedge clock);
		#1 go = value;
	endtask

	task automatic expect_quiet(int cycles, string what);
		bit seen;
		seen = 1'b0;
		repeat (cycles)
		begin
			@(negedge clock);
			assert (seen || !plot) else
			begin
				seen = 1'b1;
				note_failure(what);
			end
		end
	endtask

	task automatic wait_for_plot(string what);
		int waited;
		waited = 0;
		while (!aborted && !plot && waited < wait_limit)
		begin
			@(negedge clock);
			waited++;
		end
		if (!aborted && !plot)
		begin
			aborted = 1'b1;
			note_failure({"Timed out waiting for ", what});
		end
	endtask

	function automatic bit on_lane(int pos, int origin);
		return pos >= origin && (pos - origin) % `BLOCK_STEP == 0
			&& (pos - origin) / `BLOCK_STEP < `LANE_COUNT;
	endfunction

	// A block leaves once its next step would take it off the lane grid
	function automatic block_t advance_square(block_t s);
		block_t n;
		int nx;
		int ny;
		n = s;
		nx = s.x;
		ny = s.y;
		case (s.heading)
			heading_down: ny = ny + `BLOCK_STEP;
			heading_left: nx = nx - `BLOCK_STEP;
			heading_up: ny = ny - `BLOCK_STEP;
			default: nx = nx + `BLOCK_STEP;
		endcase
		n.occupied = on_lane(nx, `LANE_ORIGIN_X) && on_lane(ny, `LANE_ORIGIN_Y);
		n.x = coord_x_t'(nx);
		n.y = coord_y_t'(ny);
		return n;
	endfunction

	function automatic bit on_entry_edge(heading_t h, int x, int y);
		case (h)
			heading_down: return on_lane(x, `LANE_ORIGIN_X) && y == `LANE_ORIGIN_Y;
			heading_up: return on_lane(x, `LANE_ORIGIN_X) && y == `LANE_LAST_Y;
			heading_left: return x == `LANE_LAST_X && on_lane(y, `LANE_ORIGIN_Y);
			default: return x == `LANE_ORIGIN_X && on_lane(y, `LANE_ORIGIN_Y);
		endcase
	endfunction

	task automatic collect_draw();
		int quiet;
		int cycles;
		draw_x.delete();
		draw_y.delete();
		@(negedge clock);
		wait_for_plot("a draw pass to start");
		quiet = 0;
		cycles = 0;
		while (!aborted && quiet < quiet_end && cycles < pass_limit)
		begin
			if (plot)
			begin
				quiet = 0;
				draw_x.push_back(pixel.x);
				draw_y.push_back(pixel.y);
				check_value("pixel.colour", pixel.colour, `BLOCK_COLOUR);
			end
			else
				quiet++;
			cycles++;
			@(negedge clock);
		end
		if (!aborted && cycles >= pass_limit)
		begin
			aborted = 1'b1;
			note_failure("A draw pass did not end within the timeout");
		end
	endtask

	// Erase must replay the draw pass in the same order
	task automatic collect_erase();
		for (int i = 0; i < draw_x.size() && !aborted; i++)
		begin
			wait_for_plot("an erase pixel");
			if (!aborted)
			begin
				check_value("pixel.x", pixel.x, draw_x[i]);
				check_value("pixel.y", pixel.y, draw_y[i]);
				check_value("pixel.colour", pixel.colour, `ERASE_COLOUR);
				@(negedge clock);
			end
		end
	endtask

	task automatic check_frame(heading_t spawn_heading, output int count);
		block_t moved [$];
		block_t next [$];
		block_t s;
		int cx;
		int cy;
		int found;
		int spawned;
		count = draw_x.size() / square_pixels;
		assert (draw_x.size() % square_pixels == 0)
		else note_failure("A draw pass did not end on a whole square");
		check_value("squares drawn", count, (frame < `LANE_COUNT) ? frame : `LANE_COUNT);
		foreach (squares[i])
		begin
			s = advance_square(squares[i]);
			if (s.occupied)
				moved.push_back(s);
		end
		spawned = 0;
		for (int q = 0; q < count; q++)
		begin
			cx = draw_x[q * square_pixels];
			cy = draw_y[q * square_pixels];
			for (int p = 0; p < square_pixels; p++)
			begin
				check_value("pixel.x", draw_x[q * square_pixels + p], cx + p % `BLOCK_SIZE);
				check_value("pixel.y", draw_y[q * square_pixels + p], cy + p / `BLOCK_SIZE);
			end
			found = -1;
			foreach (moved[m])
				if (found < 0 && moved[m].x == cx && moved[m].y == cy)
					found = m;
			if (found >= 0)
			begin
				next.push_back(moved[found]);
				moved.delete(found);
			end
			else
			begin
				spawned++;
				assert (on_entry_edge(spawn_heading, cx, cy))
				else note_failure($sformatf("New square at x %0d y %0d is off the entry edge",
					cx, cy));
				s.occupied = 1'b1;
				s.heading = spawn_heading;
				s.x = coord_x_t'(cx);
				s.y = coord_y_t'(cy);
				next.push_back(s);
			end
		end
		check_value("new squares", spawned, 1);
		check_value("moved squares missing", moved.size(), 0);
		squares = next;
	endtask

	initial
	begin
		int fd;
		int h;
		int frames;
		int expected;
		int count;
		string line;
		void'($urandom(31));
		reset = 1'b0;
		go = 1'b0;
		heading = heading_down;

		fd = $fopen("verif/block_patterns.txt", "r");
		if (fd == 0)
		begin
			aborted = 1'b1;
			note_failure("The pattern file could not be opened");
		end
		else
		begin
			while ($fgets(line, fd) > 0)
			begin
				if ($sscanf(line, "%d %d %d", h, frames, expected) == 3) // Comment lines fail here
				begin
					pat_heading.push_back(h);
					pat_frames.push_back(frames);
					pat_count.push_back(expected);
				end
			end
			$fclose(fd);
			if (pat_heading.size() == 0)
			begin
				aborted = 1'b1;
				note_failure("The pattern file holds no pattern lines");
			end
			else
				heading = heading_t'(pat_heading[0]);
		end

		repeat (10) @(posedge clock);
		#1 reset = 1'b1;

		expect_quiet(100, "Plot went high before go was pressed");
		drive_go(1'b1);
		expect_quiet(100, "Plot went high while go was held");
		drive_go(1'b0);

		frame = 0;
		squares.delete();
		for (int i = 0; i < pat_heading.size() && !aborted; i++)
			for (int f = 0; f < pat_frames[i] && !aborted; f++)
			begin
				frame++;
				collect_draw();
				// The next capture comes after the erase pass, so the heading may change now
				if (f == pat_frames[i] - 1 && i + 1 < pat_heading.size())
				begin
					@(posedge clock);
					#1 heading = heading_t'(pat_heading[i + 1]);
					@(negedge clock);
				end
				check_frame(heading_t'(pat_heading[i]), count);
				if (f == pat_frames[i] - 1)
					check_value("squares in the last frame of a line", count, pat_count[i]);
				collect_erase();
			end

		// Reset somewhere inside the next draw pass
		if (!aborted)
		begin
			wait_for_plot("the draw pass before reset");
			repeat ($urandom_range(300, 20)) @(negedge clock);
			@(posedge clock);
			#1 reset = 1'b0;
			repeat (2) @(negedge clock);
			assert (!plot) else note_failure("Plot stayed high after reset");
			expect_quiet(3, "Plot went high during reset");
			@(posedge clock);
			#1 reset = 1'b1;
			expect_quiet(100, "Plot went high after reset without go");
			drive_go(1'b1);
			expect_quiet(50, "Plot went high while go was held after reset");
			drive_go(1'b0);
			frame = 1;
			squares.delete();
			collect_draw();
			check_frame(heading, count);
			check_value("squares in the first frame after reset", count, 1);
			collect_erase();
		end

		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== verif/block_patterns.txt ====
# Columns: heading (0 down, 1 left, 2 up, 3 right), frames to run on it,
# and squares expected in the last of those frames
0 3 3
1 2 5
2 4 5
3 3 5
0 1 5
1 6 5
2 2 5
3 1 5

// ==== filelist.f ====
+incdir+rtl
rtl/screen_pkg.sv
rtl/game_pkg.sv
rtl/game_control.sv
rtl/lane_generator.sv
rtl/block_slots.sv
rtl/square_painter.sv
rtl/block_game_top.sv
verif/tb_block_game.sv

// ==== Bender.yml ====
package:
  name: block_game

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/screen_pkg.sv
      - rtl/game_pkg.sv
      - rtl/game_control.sv
      - rtl/lane_generator.sv
      - rtl/block_slots.sv
      - rtl/square_painter.sv
      - rtl/block_game_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/tb_block_game.sv
